// File: hw/sonic_fifo_config.svh
// fifo size macros, included by the package, the fifo rtl and the testbench
`ifndef SONIC_FIFO_CONFIG_SVH
`define SONIC_FIFO_CONFIG_SVH

// ------------------------------
// storage geometry
// ------------------------------

// address bits into the storage array
`define SONIC_FIFO_ADDR_W 4

// entry count, always a power of two
// the pointers carry one extra wrap bit on top of the address
`define SONIC_FIFO_DEPTH (1 << `SONIC_FIFO_ADDR_W)

// ------------------------------
// payload
// ------------------------------

// bits per stored word
`define SONIC_FIFO_DATA_W 16

`endif

// File: hw/sonic_fifo_pkg.sv
// shared fifo types, the data word and the pointer union, imported by the fifo rtl
`default_nettype none

`include "sonic_fifo_config.svh"

package sonic_fifo_pkg;

	// one stored word
	typedef logic [`SONIC_FIFO_DATA_W-1:0] fifo_data_t;

	// pointer split view
	// msb is the wrap bit, the rest addresses the array
	typedef struct packed {
		logic                         wrap;
		logic [`SONIC_FIFO_ADDR_W-1:0] addr;
	} fifo_ptr_s;

	// one pointer word, seen two ways
	// raw for counting and crossing, fields for addressing and flags
	typedef union packed {
		logic [`SONIC_FIFO_ADDR_W:0] raw;
		fifo_ptr_s                   f;
	} fifo_ptr_u;

endpackage

`default_nettype wire

// File: hw/sonic_common_gray_clock_crosser.sv
// moves a binary count into another clock domain via gray code and a 3-flop synchronizer
`timescale 1ns/10ps
`default_nettype none

module sonic_common_gray_clock_crosser #(
	parameter int WIDTH = 8
) (
	// source side
	input  wire logic             i_inclock,
	// destination side
	input  wire logic             i_outclock_dst,
	// async reset, active high, both sides
	input  wire logic             i_outclock,
	input  wire logic [WIDTH-1:0] i_data,
	output logic      [WIDTH-1:0] o_q
);

	// depth of the destination synchronizer
	localparam int SYNC_STAGES = 3;

	// gray copy of the count, source domain
	logic [WIDTH-1:0] gray_q;

	// synchronizer chain, top index takes the crossing value
	// index 0 is the oldest and settled stage
	logic [WIDTH-1:0] sync_q [0:SYNC_STAGES-1];

	// decoded binary
	logic [WIDTH-1:0] bin_d;
	logic [WIDTH-1:0] bin_q;

	// ------------------------------
	// source domain
	// ------------------------------

	// binary to gray, registered so the crossing bus is glitch free
	always_ff @(posedge i_inclock or posedge i_outclock) begin
		if (i_outclock) begin
			gray_q <= '0;
		end else begin
			gray_q <= i_data ^ (i_data >> 1);
		end
	end

	// ------------------------------
	// destination domain
	// ------------------------------

	// shift toward index 0
	always_ff @(posedge i_outclock_dst or posedge i_outclock) begin
		if (i_outclock) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < SYNC_STAGES-1; i++) begin
				sync_q[i] <= sync_q[i+1];
			end
			// the actual domain crossing
			sync_q[SYNC_STAGES-1] <= gray_q;
		end
	end

	// gray to binary
	// each bit is the xor of all gray bits at and above it
	always_comb begin
		bin_d[WIDTH-1] = sync_q[0][WIDTH-1];
		for (int i = WIDTH-2; i >= 0; i--) begin
			bin_d[i] = bin_d[i+1] ^ sync_q[0][i];
		end
	end

	// decode register, one more destination edge
	always_ff @(posedge i_outclock_dst or posedge i_outclock) begin
		if (i_outclock) begin
			bin_q <= '0;
		end else begin
			bin_q <= bin_d;
		end
	end

	assign o_q = bin_q;

endmodule

`default_nettype wire

// File: hw/sonic_fifo_wr_ctrl.sv
// write side of the async fifo: write pointer, memory write strobe and full flag
`timescale 1ns/10ps
`default_nettype none

`include "sonic_fifo_config.svh"

module sonic_fifo_wr_ctrl (
	// write clock
	input  wire logic                          i_reset,
	// async reset, active high
	input  wire logic                          i_outclock,
	input  wire logic                          i_wr_en,
	// read pointer, already in this domain
	input  wire sonic_fifo_pkg::fifo_ptr_u     i_rd_ptr_sync,
	output sonic_fifo_pkg::fifo_ptr_u          o_wr_ptr,
	output logic                               o_mem_we,
	output logic [`SONIC_FIFO_ADDR_W-1:0]      o_mem_waddr,
	output logic                               o_full
);

	import sonic_fifo_pkg::*;

	// next slot to write, with wrap bit
	fifo_ptr_u wr_ptr_q;

	// flag and strobe
	logic full;
	logic wr_accept;

	// ------------------------------
	// full detect
	// ------------------------------

	// same slot but one lap ahead of the reader
	// late read pointer only makes this stick longer, never release early
	assign full = (wr_ptr_q.f.addr == i_rd_ptr_sync.f.addr) &&
		(wr_ptr_q.f.wrap != i_rd_ptr_sync.f.wrap);

	// writes while full get dropped here
	assign wr_accept = i_wr_en && !full;

	// ------------------------------
	// pointer
	// ------------------------------

	// one step per accepted write
	// keeps the crossed gray value to a single bit change
	always_ff @(posedge i_reset or posedge i_outclock) begin
		if (i_outclock) begin
			wr_ptr_q.raw <= '0;
		end else if (wr_accept) begin
			wr_ptr_q.raw <= wr_ptr_q.raw + 1'b1;
		end
	end

	// memory side, same cycle as the accept
	assign o_mem_we    = wr_accept;
	assign o_mem_waddr = wr_ptr_q.f.addr;

	// raw pointer out to the crosser
	assign o_wr_ptr = wr_ptr_q;
	assign o_full   = full;

endmodule

`default_nettype wire

// File: hw/sonic_fifo_rd_ctrl.sv
// read side of the async fifo: read pointer, memory read strobe, valid pulse and empty flag
`timescale 1ns/10ps
`default_nettype none

`include "sonic_fifo_config.svh"

module sonic_fifo_rd_ctrl (
	// read clock
	input  wire logic                          i_reset_rd,
	// async reset, active high
	input  wire logic                          i_outclock,
	input  wire logic                          i_rd_en,
	// write pointer, already in this domain
	input  wire sonic_fifo_pkg::fifo_ptr_u     i_wr_ptr_sync,
	output sonic_fifo_pkg::fifo_ptr_u          o_rd_ptr,
	output logic                               o_mem_re,
	output logic [`SONIC_FIFO_ADDR_W-1:0]      o_mem_raddr,
	output logic                               o_empty,
	output logic                               o_rd_valid
);

	import sonic_fifo_pkg::*;

	// next slot to read, with wrap bit
	fifo_ptr_u rd_ptr_q;

	logic empty;
	logic rd_accept;

	// valid follows the memory output register
	logic rd_valid_q;

	// ------------------------------
	// empty detect
	// ------------------------------

	// equal including wrap bit means nothing left
	// stale write pointer keeps it high a little longer
	assign empty = (rd_ptr_q.raw == i_wr_ptr_sync.raw);

	// reads while empty get dropped
	assign rd_accept = i_rd_en && !empty;

	// ------------------------------
	// pointer and valid
	// ------------------------------

	always_ff @(posedge i_reset_rd or posedge i_outclock) begin
		if (i_outclock) begin
			rd_ptr_q.raw <= '0;
		end else if (rd_accept) begin
			rd_ptr_q.raw <= rd_ptr_q.raw + 1'b1;
		end
	end

	// one cycle pulse, lines up with o_rdata of the ram
	always_ff @(posedge i_reset_rd or posedge i_outclock) begin
		if (i_outclock) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= rd_accept;
		end
	end

	// memory side
	assign o_mem_re    = rd_accept;
	assign o_mem_raddr = rd_ptr_q.f.addr;

	assign o_rd_ptr   = rd_ptr_q;
	assign o_empty    = empty;
	assign o_rd_valid = rd_valid_q;

endmodule

`default_nettype wire

// File: hw/sonic_fifo_ram.sv
// fifo storage: simple dual-port array, written on the write clock, registered read on the other
`timescale 1ns/10ps
`default_nettype none

`include "sonic_fifo_config.svh"

module sonic_fifo_ram (
	// write clock
	input  wire logic                          i_reset,
	// read clock
	input  wire logic                          i_reset_rd,
	input  wire logic                          i_we,
	input  wire logic [`SONIC_FIFO_ADDR_W-1:0] i_waddr,
	input  wire sonic_fifo_pkg::fifo_data_t    i_wdata,
	input  wire logic                          i_re,
	input  wire logic [`SONIC_FIFO_ADDR_W-1:0] i_raddr,
	output sonic_fifo_pkg::fifo_data_t         o_rdata
);

	import sonic_fifo_pkg::*;

	// the array itself
	fifo_data_t mem [0:`SONIC_FIFO_DEPTH-1];

	// read data register
	fifo_data_t rdata_q;

	// write port
	always_ff @(posedge i_reset) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end
	end

	// read port, holds last word between reads
	always_ff @(posedge i_reset_rd) begin
		if (i_re) begin
			rdata_q <= mem[i_raddr];
		end
	end

	assign o_rdata = rdata_q;

endmodule

`default_nettype wire

// File: hw/sonic_async_fifo.sv
// dual-clock fifo top: two pointer controllers, two gray pointer crossers and the storage array
`timescale 1ns/10ps
`default_nettype none

`include "sonic_fifo_config.svh"

module sonic_async_fifo (
	// write clock
	input  wire logic                       i_reset,
	// read clock
	input  wire logic                       i_reset_rd,
	// async reset, active high, both domains
	input  wire logic                       i_outclock,
	// write side
	input  wire logic                       i_wr_en,
	input  wire sonic_fifo_pkg::fifo_data_t i_wr_data,
	output logic                            o_full,
	// read side
	input  wire logic                       i_rd_en,
	output sonic_fifo_pkg::fifo_data_t      o_rd_data,
	output logic                            o_rd_valid,
	output logic                            o_empty
);

	import sonic_fifo_pkg::*;

	// local pointers
	fifo_ptr_u wr_ptr;
	fifo_ptr_u rd_ptr;

	// pointers after crossing
	fifo_ptr_u wr_ptr_sync;
	fifo_ptr_u rd_ptr_sync;

	// memory strobes and addresses
	logic                          mem_we;
	logic [`SONIC_FIFO_ADDR_W-1:0] mem_waddr;
	logic                          mem_re;
	logic [`SONIC_FIFO_ADDR_W-1:0] mem_raddr;

	// ------------------------------
	// write domain
	// ------------------------------

	sonic_fifo_wr_ctrl u_wr_ctrl (
		.i_reset       (i_reset),
		.i_outclock    (i_outclock),
		.i_wr_en       (i_wr_en),
		.i_rd_ptr_sync (rd_ptr_sync),
		.o_wr_ptr      (wr_ptr),
		.o_mem_we      (mem_we),
		.o_mem_waddr   (mem_waddr),
		.o_full        (o_full)
	);

	// ------------------------------
	// pointer crossings
	// ------------------------------

	// write pointer into the read domain, feeds empty
	sonic_common_gray_clock_crosser #(
		.WIDTH (`SONIC_FIFO_ADDR_W + 1)
	) u_wr_ptr_cross (
		.i_inclock      (i_reset),
		.i_outclock_dst (i_reset_rd),
		.i_outclock     (i_outclock),
		.i_data         (wr_ptr.raw),
		.o_q            (wr_ptr_sync)
	);

	// read pointer into the write domain, feeds full
	sonic_common_gray_clock_crosser #(
		.WIDTH (`SONIC_FIFO_ADDR_W + 1)
	) u_rd_ptr_cross (
		.i_inclock      (i_reset_rd),
		.i_outclock_dst (i_reset),
		.i_outclock     (i_outclock),
		.i_data         (rd_ptr.raw),
		.o_q            (rd_ptr_sync)
	);

	// ------------------------------
	// read domain and storage
	// ------------------------------

	sonic_fifo_rd_ctrl u_rd_ctrl (
		.i_reset_rd    (i_reset_rd),
		.i_outclock    (i_outclock),
		.i_rd_en       (i_rd_en),
		.i_wr_ptr_sync (wr_ptr_sync),
		.o_rd_ptr      (rd_ptr),
		.o_mem_re      (mem_re),
		.o_mem_raddr   (mem_raddr),
		.o_empty       (o_empty),
		.o_rd_valid    (o_rd_valid)
	);

	sonic_fifo_ram u_ram (
		.i_reset    (i_reset),
		.i_reset_rd (i_reset_rd),
		.i_we       (mem_we),
		.i_waddr    (mem_waddr),
		.i_wdata    (i_wr_data),
		.i_re       (mem_re),
		.i_raddr    (mem_raddr),
		.o_rdata    (o_rd_data)
	);

endmodule

`default_nettype wire

// File: verif/tb_sonic_async_fifo.sv
// testbench for the dual-clock fifo that is compiled with sonic_async_fifo.f and run by run_sim.sh
`timescale 1ns/10ps
`default_nettype none

`include "sonic_fifo_config.svh"

module tb_sonic_async_fifo;

	import sonic_fifo_pkg::*;

	// galois feedback mask and start state
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	localparam logic [31:0] LFSR_SEED = 32'heb17_e6f1;

	// read cycles of empty with no valid before the fifo counts as drained
	// longer than one write edge plus four read edges of pointer crossing
	localparam int DRAIN_QUIET = 8;

	// free running write and read clocks
	logic       i_reset = 1'b0;
	logic       i_reset_rd = 1'b0;
	logic       i_outclock;
	logic       i_wr_en;
	fifo_data_t i_wr_data;
	logic       o_full;
	logic       i_rd_en;
	fifo_data_t o_rd_data;
	logic       o_rd_valid;
	logic       o_empty;

	// words accepted by the dut but not yet read back
	fifo_data_t model_q [$];

	// phase label for error lines
	string test_name = "reset";

	// separate state per domain
	logic [31:0] wr_lfsr;
	logic [31:0] rd_lfsr;

	// event counters with a single writer process each
	int wr_accepts = 0;
	int valid_count = 0;
	int data_errors = 0;
	int stray_valid_errors = 0;
	int overflow_errors = 0;
	int flag_errors = 0;
	int count_errors = 0;
	int timeout_errors = 0;

	// 10 ns write clock and 14 ns read clock
	always #5 i_reset = ~i_reset;
	always #7 i_reset_rd = ~i_reset_rd;

	sonic_async_fifo u_sonic_async_fifo (
		.i_reset    (i_reset),
		.i_reset_rd (i_reset_rd),
		.i_outclock (i_outclock),
		.i_wr_en    (i_wr_en),
		.i_wr_data  (i_wr_data),
		.o_full     (o_full),
		.i_rd_en    (i_rd_en),
		.o_rd_data  (o_rd_data),
		.o_rd_valid (o_rd_valid),
		.o_empty    (o_empty)
	);

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	// newest bit lands in bit 0
	task automatic draw_bits(inout logic [31:0] state, input int nbits,
			output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			state = lfsr_next(state);
			value = {value[30:0], state[0]};
		end
	endtask

	// head of the model is the next word the fifo must return
	function automatic fifo_data_t expected_word();
		return model_q[0];
	endfunction

	// ------------------------------
	// compare tasks
	// ------------------------------

	task automatic check_data(input string name, input fifo_data_t exp, input fifo_data_t act);
		if (act !== exp) begin
			data_errors++;
			$display("mismatch %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			flag_errors++;
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			count_errors++;
			$display("mismatch %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// ------------------------------
	// monitors
	// ------------------------------

	// accepted write by the same rule as the write side
	always @(posedge i_reset) begin
		if (!i_outclock && i_wr_en && !o_full) begin
			model_q.push_back(i_wr_data);
			wr_accepts++;
			if (model_q.size() > `SONIC_FIFO_DEPTH) begin
				overflow_errors++;
				$display("error in %s: more words outstanding than the fifo holds",
					test_name);
			end
		end
	end

	// valid sampled mid cycle of the read clock
	always @(negedge i_reset_rd) begin
		if (o_rd_valid) begin
			valid_count++;
			if (model_q.size() == 0) begin
				stray_valid_errors++;
				$display("error in %s: read data came out but nothing was written",
					test_name);
			end else begin
				check_data(test_name, expected_word(), o_rd_data);
				void'(model_q.pop_front());
			end
		end
	end

	// ------------------------------
	// drivers and waits
	// ------------------------------

	task automatic write_words(input int n);
		logic [31:0] bits;
		for (int i = 0; i < n; i++) begin
			@(negedge i_reset);
			draw_bits(wr_lfsr, `SONIC_FIFO_DATA_W, bits);
			i_wr_en   = 1'b1;
			i_wr_data = bits[`SONIC_FIFO_DATA_W-1:0];
		end
		@(negedge i_reset);
		i_wr_en = 1'b0;
	endtask

	// lets the read pointer reach the write side
	task automatic idle_writes(input int n);
		repeat (n) @(negedge i_reset);
	endtask

	task automatic write_until_full(input int max_cycles);
		logic [31:0] bits;
		bit          seen;
		seen = 1'b0;
		for (int i = 0; i < max_cycles && !seen; i++) begin
			@(negedge i_reset);
			if (o_full) begin
				seen = 1'b1;
			end else begin
				draw_bits(wr_lfsr, `SONIC_FIFO_DATA_W, bits);
				i_wr_en   = 1'b1;
				i_wr_data = bits[`SONIC_FIFO_DATA_W-1:0];
			end
		end
		i_wr_en = 1'b0;
		if (!seen) begin
			timeout_errors++;
			$display("timeout in %s: o_full never rose while writing", test_name);
		end
	endtask

	task automatic wait_full_low(input int max_cycles);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < max_cycles && !seen; i++) begin
			@(negedge i_reset);
			seen = !o_full;
		end
		if (!seen) begin
			timeout_errors++;
			$display("timeout in %s: o_full never fell after a read", test_name);
		end
	endtask

	task automatic wait_empty_low(input int max_cycles);
		bit seen;
		seen = 1'b0;
		for (int i = 0; i < max_cycles && !seen; i++) begin
			@(negedge i_reset_rd);
			seen = !o_empty;
		end
		if (!seen) begin
			timeout_errors++;
			$display("timeout in %s: o_empty never fell after a write", test_name);
		end
	endtask

	// read until the fifo stays empty with nothing in flight
	// the model is left alone so a lost word shows up afterwards
	task automatic drain(input int max_cycles);
		int quiet;
		bit done;
		quiet = 0;
		done  = 1'b0;
		for (int i = 0; i < max_cycles && !done; i++) begin
			@(negedge i_reset_rd);
			if (o_empty && !o_rd_valid) begin
				quiet++;
			end else begin
				quiet = 0;
			end
			done    = (quiet >= DRAIN_QUIET);
			i_rd_en = !done;
		end
		i_rd_en = 1'b0;
		if (!done) begin
			timeout_errors++;
			$display("timeout in %s: fifo never drained", test_name);
		end
	endtask

	// n read requests then two quiet cycles
	task automatic read_pulses(input int n);
		repeat (n) begin
			@(negedge i_reset_rd);
			i_rd_en = 1'b1;
		end
		@(negedge i_reset_rd);
		i_rd_en = 1'b0;
		@(negedge i_reset_rd);
	endtask

	// about half the write cycles carry a word
	task automatic random_writes(input int n);
		logic [31:0] bits;
		for (int i = 0; i < n; i++) begin
			@(negedge i_reset);
			draw_bits(wr_lfsr, 1, bits);
			i_wr_en = bits[0];
			draw_bits(wr_lfsr, `SONIC_FIFO_DATA_W, bits);
			i_wr_data = bits[`SONIC_FIFO_DATA_W-1:0];
		end
		@(negedge i_reset);
		i_wr_en = 1'b0;
	endtask

	// three of four read cycles request
	task automatic random_reads(input int n);
		logic [31:0] bits;
		for (int i = 0; i < n; i++) begin
			@(negedge i_reset_rd);
			draw_bits(rd_lfsr, 2, bits);
			i_rd_en = |bits[1:0];
		end
		@(negedge i_reset_rd);
		i_rd_en = 1'b0;
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		int start;
		int total;
		i_outclock = 1'b1;
		i_wr_en    = 1'b0;
		i_wr_data  = '0;
		i_rd_en    = 1'b0;
		wr_lfsr    = LFSR_SEED;
		rd_lfsr    = LFSR_SEED;
		repeat (5) @(negedge i_reset);
		i_outclock = 1'b0;
		@(negedge i_reset_rd);
		check_flag("reset_empty", 1'b1, o_empty);
		check_flag("reset_full", 1'b0, o_full);
		check_flag("reset_valid", 1'b0, o_rd_valid);

		// in order with reads idle while writing
		test_name = "order";
		start = wr_accepts;
		write_words(8);
		check_count("order_accepts", 8, wr_accepts - start);
		drain(200);
		check_count("order_left", 0, model_q.size());

		// fill up and drop the extra writes
		test_name = "full";
		idle_writes(8);
		start = wr_accepts;
		write_until_full(4 * `SONIC_FIFO_DEPTH);
		check_count("full_accepts", `SONIC_FIFO_DEPTH, wr_accepts - start);
		write_words(4);
		check_count("full_dropped", `SONIC_FIFO_DEPTH, wr_accepts - start);
		check_flag("full_held", 1'b1, o_full);

		// one read must free the write side
		test_name = "full_release";
		read_pulses(1);
		wait_full_low(40);
		drain(300);
		check_count("full_left", 0, model_q.size());

		// reads on an empty fifo give nothing
		test_name = "empty";
		start = valid_count;
		read_pulses(8);
		check_count("empty_reads", 0, valid_count - start);

		test_name = "empty_release";
		write_words(1);
		wait_empty_low(40);
		drain(100);

		// both sides at random rates
		test_name = "random";
		fork
			random_writes(4000);
			random_reads(2800);
		join
		drain(400);
		check_count("random_left", 0, model_q.size());

		total = data_errors + stray_valid_errors + overflow_errors + flag_errors +
			count_errors + timeout_errors;
		$display("errors: data %0d, stray %0d, overflow %0d, flag %0d, count %0d, timeout %0d",
			data_errors, stray_valid_errors, overflow_errors, flag_errors, count_errors,
			timeout_errors);
		if (total == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sonic_async_fifo.f
+incdir+hw
hw/sonic_fifo_pkg.sv
hw/sonic_common_gray_clock_crosser.sv
hw/sonic_fifo_wr_ctrl.sv
hw/sonic_fifo_rd_ctrl.sv
hw/sonic_fifo_ram.sv
hw/sonic_async_fifo.sv
verif/tb_sonic_async_fifo.sv

// File: run_sim.sh
#!/bin/sh
# build the fifo testbench with verilator, run it, pass only on the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --top-module tb_sonic_async_fifo -f sonic_async_fifo.f -o sim_fifo \
	|| exit 1

out="$(./obj_dir/sim_fifo 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'TEST RESULT: PASS' && exit 0 || exit 1
